// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int DBITS          = 32;
  localparam int REGNOBITS      = 4;
  localparam int IMMBITS        = 16;
  localparam int OP1BITS        = 6;
  localparam int OP2BITS        = 8;
  localparam int HEXBITS        = 24;
  localparam int LEDRBITS       = 10;
  localparam int SWBITS         = 10;
  localparam int IMEM_ADDR_BITS = 16;  // byte address bits, low 2 pick the byte
  localparam int DMEM_ADDR_BITS = 16;

  typedef logic [DBITS-1:0]     word_t;
  typedef logic [DBITS-1:0]     inst_t;
  typedef logic [REGNOBITS-1:0] regno_t;
  typedef logic [OP1BITS-1:0]   op1_t;
  typedef logic [OP2BITS-1:0]   op2_t;
  typedef logic [HEXBITS-1:0]   hex_t;
  typedef logic [LEDRBITS-1:0]  ledr_t;
  typedef logic [SWBITS-1:0]    sw_t;
  typedef logic [4:0]           ctrl_t;  // is_br, is_jmp, rd_mem, wr_mem, wr_reg

  // bit positions inside ctrl_t
  localparam int CTRL_IS_BR  = 4;
  localparam int CTRL_IS_JMP = 3;
  localparam int CTRL_RD_MEM = 2;
  localparam int CTRL_WR_MEM = 1;
  localparam int CTRL_WR_REG = 0;

  localparam word_t START_PC  = 32'h0000_0100;
  localparam word_t INST_SIZE = 32'd4;

  // --------------------------------------------------------------------------
  // opcodes
  // --------------------------------------------------------------------------
  localparam op1_t OP1_ALUR = 6'b000000;
  localparam op1_t OP1_BEQ  = 6'b001000;
  localparam op1_t OP1_BLT  = 6'b001001;
  localparam op1_t OP1_BLE  = 6'b001010;
  localparam op1_t OP1_BNE  = 6'b001011;
  localparam op1_t OP1_JAL  = 6'b001100;
  localparam op1_t OP1_LW   = 6'b010010;
  localparam op1_t OP1_SW   = 6'b011010;
  localparam op1_t OP1_ADDI = 6'b100000;
  localparam op1_t OP1_ANDI = 6'b100100;
  localparam op1_t OP1_ORI  = 6'b100101;
  localparam op1_t OP1_XORI = 6'b100110;

  localparam op2_t OP2_EQ   = 8'b00001000;
  localparam op2_t OP2_LT   = 8'b00001001;
  localparam op2_t OP2_LE   = 8'b00001010;
  localparam op2_t OP2_NE   = 8'b00001011;
  localparam op2_t OP2_ADD  = 8'b00100000;
  localparam op2_t OP2_AND  = 8'b00100100;
  localparam op2_t OP2_OR   = 8'b00100101;
  localparam op2_t OP2_XOR  = 8'b00100110;
  localparam op2_t OP2_SUB  = 8'b00101000;
  localparam op2_t OP2_NAND = 8'b00101100;
  localparam op2_t OP2_NOR  = 8'b00101101;
  localparam op2_t OP2_NXOR = 8'b00101110;
  localparam op2_t OP2_RSHF = 8'b00110000;
  localparam op2_t OP2_LSHF = 8'b00110001;

  // memory-mapped i/o
  localparam word_t ADDR_HEX     = 32'hFFFF_F000;
  localparam word_t ADDR_LEDR    = 32'hFFFF_F020;
  localparam word_t ADDR_SW_DATA = 32'hFFFF_F090;
  localparam word_t ADDR_SW_CTRL = 32'hFFFF_F094;
  localparam hex_t  HEX_RESET    = 24'hFEDEAD;

endpackage

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input  logic           clk,
  input  logic           reset,
  input  logic           stall,
  input  logic           mispred,
  input  cpu_pkg::word_t pcgood,
  output cpu_pkg::inst_t inst_fe,
  output cpu_pkg::word_t pc_fe
);

  // word addressed, so START_PC sits at word 0x40 of the image
  cpu_pkg::inst_t imem [2**(cpu_pkg::IMEM_ADDR_BITS-2)];
  cpu_pkg::word_t pc;
  cpu_pkg::word_t pc_next;

  initial begin
    $readmemh("test/program.hex", imem);
  end

  assign pc_next = pc + cpu_pkg::INST_SIZE;  // always predict fall-through

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= cpu_pkg::START_PC;
      inst_fe <= '0;  // bubble
    end else if (mispred) begin
      pc      <= pcgood;
      inst_fe <= '0;
    end else if (!stall) begin
      pc      <= pc_next;
      inst_fe <= imem[pc[cpu_pkg::IMEM_ADDR_BITS-1:2]];
    end
  end

  // pc of the next instruction, base for branch offsets and jal link
  always_ff @(posedge clk) begin
    if (!stall) pc_fe <= pc_next;
  end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::inst_t  inst_fe,
  input  cpu_pkg::word_t  pc_fe,
  input  logic            mispred,
  input  cpu_pkg::word_t  ex_alu,
  input  cpu_pkg::regno_t ex_wregno,
  input  logic            ex_wr_reg,
  input  logic            ex_rd_mem,
  input  cpu_pkg::regno_t mem_wregno,
  input  logic            mem_wr_reg,
  input  cpu_pkg::word_t  mem_val,
  input  cpu_pkg::regno_t wb_regno,
  input  cpu_pkg::word_t  wb_val,
  input  logic            wb_en,
  output logic            stall,
  output cpu_pkg::op1_t   op1_id,
  output cpu_pkg::op2_t   op2_id,
  output cpu_pkg::word_t  regval1_id,
  output cpu_pkg::word_t  regval2_id,
  output cpu_pkg::word_t  imm_id,
  output cpu_pkg::word_t  pc_id,
  output cpu_pkg::regno_t wregno_id,
  output cpu_pkg::ctrl_t  ctrl_id
);

  cpu_pkg::op1_t               op1;
  cpu_pkg::op2_t               op2;
  logic [cpu_pkg::IMMBITS-1:0] imm;
  cpu_pkg::regno_t             rd;
  cpu_pkg::regno_t             rs;
  cpu_pkg::regno_t             rt;
  cpu_pkg::word_t              imm_sx;
  cpu_pkg::word_t              regs [2**cpu_pkg::REGNOBITS];
  cpu_pkg::word_t              opnd1;
  cpu_pkg::word_t              opnd2;
  cpu_pkg::ctrl_t              ctrl;
  cpu_pkg::regno_t             wregno;
  logic                        is_alur;
  logic                        uses_rt;

  // --------------------------------------------------------------------------
  // field split
  // --------------------------------------------------------------------------
  assign op1 = inst_fe[31:26];
  assign op2 = inst_fe[25:18];
  assign imm = inst_fe[23:8];
  assign rd  = inst_fe[11:8];
  assign rs  = inst_fe[7:4];
  assign rt  = inst_fe[3:0];

  assign imm_sx  = {{(cpu_pkg::DBITS-cpu_pkg::IMMBITS){imm[cpu_pkg::IMMBITS-1]}}, imm};
  assign is_alur = (op1 == cpu_pkg::OP1_ALUR);
  assign wregno  = is_alur ? rd : rt;  // only register alu ops write rd

  always_comb begin
    ctrl = '0;
    ctrl[cpu_pkg::CTRL_IS_BR]  = op1 inside {cpu_pkg::OP1_BEQ, cpu_pkg::OP1_BLT,
                                            cpu_pkg::OP1_BLE, cpu_pkg::OP1_BNE};
    ctrl[cpu_pkg::CTRL_IS_JMP] = (op1 == cpu_pkg::OP1_JAL);
    ctrl[cpu_pkg::CTRL_RD_MEM] = (op1 == cpu_pkg::OP1_LW);
    ctrl[cpu_pkg::CTRL_WR_MEM] = (op1 == cpu_pkg::OP1_SW);
    ctrl[cpu_pkg::CTRL_WR_REG] = is_alur ||
                                 op1 inside {cpu_pkg::OP1_JAL, cpu_pkg::OP1_LW,
                                             cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI,
                                             cpu_pkg::OP1_ORI, cpu_pkg::OP1_XORI};
  end

  // rt is a source only here, otherwise it is the destination
  assign uses_rt = is_alur || ctrl[cpu_pkg::CTRL_IS_BR] || ctrl[cpu_pkg::CTRL_WR_MEM];

  // --------------------------------------------------------------------------
  // register file, forwarding and load-use stall
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**cpu_pkg::REGNOBITS; i++) regs[i] <= '0;
    end else if (wb_en && wb_regno != '0) begin
      regs[wb_regno] <= wb_val;
    end
  end

  // youngest producer wins; loads in execute are left to the stall
  function automatic cpu_pkg::word_t fwd(input cpu_pkg::regno_t src,
                                         input cpu_pkg::word_t  rf_val);
    if (src == '0) return '0;
    if (ex_wr_reg && !ex_rd_mem && ex_wregno == src) return ex_alu;
    if (mem_wr_reg && mem_wregno == src) return mem_val;
    if (wb_en && wb_regno == src) return wb_val;  // written this edge
    return rf_val;
  endfunction

  always_comb begin
    opnd1 = fwd(rs, regs[rs]);
    opnd2 = fwd(rt, regs[rt]);
  end

  assign stall = ex_rd_mem && ex_wr_reg && ex_wregno != '0 &&
                 (ex_wregno == rs || (uses_rt && ex_wregno == rt));

  // --------------------------------------------------------------------------
  // decode latch
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) ctrl_id <= '0;
    else if (mispred || stall) ctrl_id <= '0;  // bubble into execute
    else ctrl_id <= ctrl;
  end

  always_ff @(posedge clk) begin
    op1_id     <= op1;
    op2_id     <= op2;
    regval1_id <= opnd1;
    regval2_id <= opnd2;
    imm_id     <= imm_sx;
    pc_id      <= pc_fe;
    wregno_id  <= wregno;
  end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::op1_t   op1_id,
  input  cpu_pkg::op2_t   op2_id,
  input  cpu_pkg::word_t  regval1_id,
  input  cpu_pkg::word_t  regval2_id,
  input  cpu_pkg::word_t  imm_id,
  input  cpu_pkg::word_t  pc_id,
  input  cpu_pkg::regno_t wregno_id,
  input  cpu_pkg::ctrl_t  ctrl_id,
  output cpu_pkg::word_t  ex_alu,
  output cpu_pkg::regno_t ex_wregno,
  output logic            ex_wr_reg,
  output logic            ex_rd_mem,
  output logic            mispred,
  output cpu_pkg::word_t  pcgood,
  output cpu_pkg::word_t  aluout_ex,
  output cpu_pkg::word_t  regval2_ex,
  output cpu_pkg::regno_t wregno_ex,
  output logic            rd_mem_ex,
  output logic            wr_mem_ex,
  output logic            wr_reg_ex
);

  logic signed [cpu_pkg::DBITS-1:0] sval1;
  logic signed [cpu_pkg::DBITS-1:0] sval2;
  logic                             br_cond;
  logic                             taken;
  logic                             live;
  cpu_pkg::word_t                   imm_x4;
  cpu_pkg::word_t                   target;

  assign sval1 = regval1_id;
  assign sval2 = regval2_id;

  // --------------------------------------------------------------------------
  // alu
  // --------------------------------------------------------------------------
  always_comb begin
    case (op1_id)
      cpu_pkg::OP1_ALUR: begin
        case (op2_id)
          cpu_pkg::OP2_EQ:   ex_alu = cpu_pkg::word_t'(sval1 == sval2);
          cpu_pkg::OP2_LT:   ex_alu = cpu_pkg::word_t'(sval1 < sval2);
          cpu_pkg::OP2_LE:   ex_alu = cpu_pkg::word_t'(sval1 <= sval2);
          cpu_pkg::OP2_NE:   ex_alu = cpu_pkg::word_t'(sval1 != sval2);
          cpu_pkg::OP2_ADD:  ex_alu = regval1_id + regval2_id;
          cpu_pkg::OP2_AND:  ex_alu = regval1_id & regval2_id;
          cpu_pkg::OP2_OR:   ex_alu = regval1_id | regval2_id;
          cpu_pkg::OP2_XOR:  ex_alu = regval1_id ^ regval2_id;
          cpu_pkg::OP2_SUB:  ex_alu = regval1_id - regval2_id;
          cpu_pkg::OP2_NAND: ex_alu = ~(regval1_id & regval2_id);
          cpu_pkg::OP2_NOR:  ex_alu = ~(regval1_id | regval2_id);
          cpu_pkg::OP2_NXOR: ex_alu = ~(regval1_id ^ regval2_id);
          cpu_pkg::OP2_RSHF: ex_alu = sval1 >>> regval2_id;  // arithmetic
          cpu_pkg::OP2_LSHF: ex_alu = regval1_id << regval2_id;
          default:           ex_alu = '0;
        endcase
      end
      cpu_pkg::OP1_LW, cpu_pkg::OP1_SW,
      cpu_pkg::OP1_ADDI: ex_alu = regval1_id + imm_id;  // also the mem address
      cpu_pkg::OP1_ANDI: ex_alu = regval1_id & imm_id;
      cpu_pkg::OP1_ORI:  ex_alu = regval1_id | imm_id;
      cpu_pkg::OP1_XORI: ex_alu = regval1_id ^ imm_id;
      cpu_pkg::OP1_JAL:  ex_alu = pc_id;  // return address
      default:           ex_alu = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // branch condition and target
  // --------------------------------------------------------------------------
  always_comb begin
    case (op1_id)
      cpu_pkg::OP1_BEQ: br_cond = (sval1 == sval2);
      cpu_pkg::OP1_BLT: br_cond = (sval1 < sval2);
      cpu_pkg::OP1_BLE: br_cond = (sval1 <= sval2);
      cpu_pkg::OP1_BNE: br_cond = (sval1 != sval2);
      default:          br_cond = 1'b0;
    endcase
  end

  assign imm_x4 = imm_id << 2;
  assign target = (op1_id == cpu_pkg::OP1_JAL) ? regval1_id + imm_x4 : pc_id + imm_x4;
  assign taken  = ctrl_id[cpu_pkg::CTRL_IS_JMP] ||
                  (ctrl_id[cpu_pkg::CTRL_IS_BR] && br_cond);

  // unlatched view for decode forwarding
  assign ex_wregno = wregno_id;
  assign ex_wr_reg = ctrl_id[cpu_pkg::CTRL_WR_REG];
  assign ex_rd_mem = ctrl_id[cpu_pkg::CTRL_RD_MEM];

  // --------------------------------------------------------------------------
  // execute latch
  // --------------------------------------------------------------------------
  assign live = !mispred;  // instruction here is wrong-path while redirecting

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mispred   <= 1'b0;
      rd_mem_ex <= 1'b0;
      wr_mem_ex <= 1'b0;
      wr_reg_ex <= 1'b0;
    end else begin
      mispred   <= live && taken;
      rd_mem_ex <= live && ctrl_id[cpu_pkg::CTRL_RD_MEM];
      wr_mem_ex <= live && ctrl_id[cpu_pkg::CTRL_WR_MEM];
      wr_reg_ex <= live && ctrl_id[cpu_pkg::CTRL_WR_REG];
    end
  end

  always_ff @(posedge clk) begin
    pcgood     <= target;
    aluout_ex  <= ex_alu;
    regval2_ex <= regval2_id;
    wregno_ex  <= wregno_id;
  end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::sw_t    sw,
  input  cpu_pkg::word_t  aluout_ex,
  input  cpu_pkg::word_t  regval2_ex,
  input  cpu_pkg::regno_t wregno_ex,
  input  logic            rd_mem_ex,
  input  logic            wr_mem_ex,
  input  logic            wr_reg_ex,
  output cpu_pkg::word_t  mem_val,
  output cpu_pkg::regno_t mem_wregno,
  output logic            mem_wr_reg,
  output cpu_pkg::regno_t wb_regno,
  output cpu_pkg::word_t  wb_val,
  output logic            wb_en,
  output cpu_pkg::hex_t   hex,
  output cpu_pkg::ledr_t  ledr
);

  cpu_pkg::word_t dmem [2**(cpu_pkg::DMEM_ADDR_BITS-2)];
  cpu_pkg::word_t rd_val;
  cpu_pkg::sw_t   sw_data;
  logic [4:0]     sw_ctrl;  // [1] overrun, [0] ready
  logic           sel_hex;
  logic           sel_ledr;
  logic           sel_sw_data;
  logic           sel_sw_ctrl;
  logic           sel_io;

  assign sel_hex     = (aluout_ex == cpu_pkg::ADDR_HEX);
  assign sel_ledr    = (aluout_ex == cpu_pkg::ADDR_LEDR);
  assign sel_sw_data = (aluout_ex == cpu_pkg::ADDR_SW_DATA);
  assign sel_sw_ctrl = (aluout_ex == cpu_pkg::ADDR_SW_CTRL);
  assign sel_io      = sel_hex || sel_ledr || sel_sw_data || sel_sw_ctrl;

  always_ff @(posedge clk) begin
    if (wr_mem_ex && !sel_io) dmem[aluout_ex[cpu_pkg::DMEM_ADDR_BITS-1:2]] <= regval2_ex;
  end

  always_comb begin
    if (sel_sw_data) rd_val = cpu_pkg::word_t'(sw_data);
    else if (sel_sw_ctrl) rd_val = cpu_pkg::word_t'(sw_ctrl);
    else rd_val = dmem[aluout_ex[cpu_pkg::DMEM_ADDR_BITS-1:2]];
  end

  assign mem_val    = rd_mem_ex ? rd_val : aluout_ex;
  assign mem_wregno = wregno_ex;
  assign mem_wr_reg = wr_reg_ex;

  // --------------------------------------------------------------------------
  // i/o registers and switch device
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= cpu_pkg::HEX_RESET;
      ledr <= '0;
    end else if (wr_mem_ex) begin
      if (sel_hex) hex <= regval2_ex[cpu_pkg::HEXBITS-1:0];
      if (sel_ledr) ledr <= regval2_ex[cpu_pkg::LEDRBITS-1:0];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sw_data <= '0;
      sw_ctrl <= '0;
    end else begin
      sw_data <= sw;
      if (sw_data != sw) begin  // change seen
        sw_ctrl[0] <= 1'b1;
        if (sw_ctrl[0]) sw_ctrl[1] <= 1'b1;  // previous value never read
      end else if (rd_mem_ex && sel_sw_data) begin
        sw_ctrl[0] <= 1'b0;
      end else if (wr_mem_ex && sel_sw_ctrl) begin
        sw_ctrl[4:1] <= {regval2_ex[4:2], regval2_ex[1] & sw_ctrl[1]};
      end
    end
  end

  // writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) wb_en <= 1'b0;
    else wb_en <= wr_reg_ex;
  end

  always_ff @(posedge clk) begin
    wb_regno <= wregno_ex;
    wb_val   <= mem_val;
  end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::sw_t   sw,
  output cpu_pkg::hex_t  hex,
  output cpu_pkg::ledr_t ledr
);

  // fetch -> decode
  cpu_pkg::inst_t  inst_fe;
  cpu_pkg::word_t  pc_fe;
  logic            stall;

  // decode -> execute
  cpu_pkg::op1_t   op1_id;
  cpu_pkg::op2_t   op2_id;
  cpu_pkg::word_t  regval1_id;
  cpu_pkg::word_t  regval2_id;
  cpu_pkg::word_t  imm_id;
  cpu_pkg::word_t  pc_id;
  cpu_pkg::regno_t wregno_id;
  cpu_pkg::ctrl_t  ctrl_id;

  // execute -> decode (forwarding, load-use) and redirect
  cpu_pkg::word_t  ex_alu;
  cpu_pkg::regno_t ex_wregno;
  logic            ex_wr_reg;
  logic            ex_rd_mem;
  logic            mispred;
  cpu_pkg::word_t  pcgood;

  // execute -> memory
  cpu_pkg::word_t  aluout_ex;
  cpu_pkg::word_t  regval2_ex;
  cpu_pkg::regno_t wregno_ex;
  logic            rd_mem_ex;
  logic            wr_mem_ex;
  logic            wr_reg_ex;

  // memory -> decode
  cpu_pkg::word_t  mem_val;
  cpu_pkg::regno_t mem_wregno;
  logic            mem_wr_reg;
  cpu_pkg::regno_t wb_regno;
  cpu_pkg::word_t  wb_val;
  logic            wb_en;

  // all port names line up with the nets above
  fetch_stage fetch_stage_i (.*);

  decode_stage decode_stage_i (.*);

  execute_stage execute_stage_i (.*);

  mem_stage mem_stage_i (.*);

endmodule

// ==== test/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

  localparam int MAX_PATTERNS       = 64;
  localparam int FIELD_BITS         = 24;
  localparam int CYCLES_PER_PATTERN = 40;
  localparam int BASE_CYCLES        = 200;

  // pattern kinds
  localparam int KIND_END  = 0;
  localparam int KIND_HEX  = 1;
  localparam int KIND_LEDR = 2;
  localparam int KIND_SW   = 3;

  logic           clk;
  logic           reset;
  cpu_pkg::sw_t   sw;
  cpu_pkg::hex_t  hex;
  cpu_pkg::ledr_t ledr;

  logic [FIELD_BITS-1:0] patterns [2*MAX_PATTERNS];  // kind, value pairs
  int             num_patterns = 0;
  int             cycle_count  = 0;
  int             cycle_limit  = 0;  // 0 while the limit is unknown
  int             pass_count   = 0;
  int             fail_count   = 0;
  cpu_pkg::hex_t  last_hex;
  cpu_pkg::ledr_t last_ledr;

  cpu_top cpu_top_i (
    .clk   (clk),
    .reset (reset),
    .sw    (sw),
    .hex   (hex),
    .ledr  (ledr)
  );

  always #10 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout: the DUT did not reach the expected outputs in %0d cycles",
               cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input int test_no, input string name,
                             input logic [FIELD_BITS-1:0] got,
                             input logic [FIELD_BITS-1:0] expected);
    assert (got === expected) begin
      pass_count++;
      $display("test %0d: %s = %h ok", test_no, name, got);
    end else begin
      fail_count++;
      $display("[ERROR] test %0d: %s = %h, expected %h", test_no, name, got, expected);
    end
  endtask

  // outputs are looked at on the falling edge only
  task automatic wait_hex_change();
    while (hex === last_hex) @(negedge clk);
    last_hex = hex;
  endtask

  task automatic wait_ledr_change();
    while (ledr === last_ledr) @(negedge clk);
    last_ledr = ledr;
  endtask

  task automatic drive_sw(input int test_no, input logic [FIELD_BITS-1:0] value);
    @(posedge clk);
    #2;
    sw = value[cpu_pkg::SWBITS-1:0];
    $display("test %0d: sw set to %h", test_no, sw);
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int                    kind;
    logic [FIELD_BITS-1:0] value;

    clk   = 1'b0;
    reset = 1'b1;
    sw    = '0;

    for (int i = 0; i < 2*MAX_PATTERNS; i++) patterns[i] = '0;
    $readmemh("test/cpu_patterns.hex", patterns);
    while (num_patterns < MAX_PATTERNS && patterns[2*num_patterns] != KIND_END) begin
      num_patterns++;
    end
    cycle_limit = CYCLES_PER_PATTERN*num_patterns + BASE_CYCLES;

    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);

    // values straight out of reset
    check_value(0, "hex", hex, 24'hFEDEAD);
    check_value(0, "ledr", FIELD_BITS'(ledr), '0);
    last_hex  = hex;
    last_ledr = ledr;

    if (num_patterns == 0) begin
      fail_count++;
      $display("the pattern file could not be read or holds no entries");
    end

    for (int i = 0; i < num_patterns; i++) begin
      kind  = int'(patterns[2*i]);
      value = patterns[2*i+1];
      case (kind)
        KIND_SW: drive_sw(i + 1, value);
        KIND_HEX: begin
          wait_hex_change();
          check_value(i + 1, "hex", hex, value);
        end
        KIND_LEDR: begin
          wait_ledr_change();
          check_value(i + 1, "ledr", FIELD_BITS'(ledr), value);
        end
        default: begin
          fail_count++;
          $display("test %0d: unknown pattern kind %0d in the pattern file", i + 1, kind);
        end
      endcase
    end

    $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/cpu_top.sv
test/cpu_tb.sv

// ==== test/program.hex ====
// instruction words from START_PC (word 0x40), a few per line
@40
80012301 80045602 80000404 80800005  // r1 123, r2 456, r4 4, r5 ffff8000
00800312 68F00003  // add, hex 579
00A00321 68F00003  // sub, hex 333
00B00312 68F00003  // nand, hex fffffd
00C40314 68F00003  // lshf by 4, hex 1230
00C00354 68F00003  // rshf keeps the sign, hex fff800
00240351 68F00003  // lt, hex 1
00200312 68F00003  // eq, hex 0
9800FF13 68F00003  // xori, hex 1dc
00280311 68F00003  // le, hex 1
9000F023 68F00003  // andi, hex 50
// running sum in r6 at distances 1, 2 and 3
80001006 80002066 80000107 80004066
80000177 80000208 80008066 68F00006  // hex f0
// store, load and use right away
68004006 48004009 00800A91 68F0000A  // hex 213
// branches, ledr markers 1 to 4
20000212 8000010B 68F0200B  // beq untaken, ledr 1
2C000212 8000BB0B 68F0200B  // bne taken over a wrong marker
8000020B 68F0200B           // ledr 2
24000251 8000CC0B 68F0200B  // blt taken
28000215 8000030B 68F0200B  // ble untaken, ledr 3
28000211 8000DD0B 68F0200B  // ble taken
3000860F                    // jal r15 to the subroutine at 218
// switch echo, twice
8000020C
48F0940D 900001DD 20FFFDD0  // poll ready
48F0900E 68F0200E           // read data, echo on ledr
48F0940D 2C0005D0           // ready and overrun must be clear
80FFFFCC 2CFFF7C0
800ACE0B 68F0000B 20FFFF00  // hex ace, then spin
800BAD0B 68F0000B 20FFFF00  // bad control word
8000040B 68F0200B 300000F0  // subroutine, ledr 4 and return
8000EE0B 68F0200B           // past the return, never reached

// ==== test/cpu_patterns.hex ====
// kind value: 1 = expect hex, 2 = expect ledr, 3 = set sw, 0 = end
// expect kinds wait for the next change on that output
1 000579
1 000333
1 FFFFFD
1 001230
1 FFF800
1 000001
1 000000
1 0001DC
1 000001
1 000050
1 0000F0
1 000213
2 000001
2 000002
2 000003
2 000004
3 0002A5
2 0002A5
3 00015A
2 00015A
1 000ACE
0 000000
